// File: include/vec_rob_macros.svh
// vector rob sizing macros
`ifndef VEC_ROB_MACROS_SVH
`define VEC_ROB_MACROS_SVH

// reorder buffer geometry
`define ROB_DEPTH   8
`define ROB_IDX_W   3
`define NUM_RT      2

// datapath and register file
`define DATA_W      32
`define VREG_COUNT  8
`define VREG_IDX_W  3
`define SEQ_W       8

// multiply pipeline depth in cycles
`define MUL_LAT     3

`endif

// File: rtl/vec_rob_pkg.sv
// vector rob shared types
package vec_rob_pkg;

  // uop opcodes
  typedef enum logic [1:0] {
    OP_ADD  = 2'b00,
    OP_SUB  = 2'b01,
    OP_MUL  = 2'b10,
    OP_TRAP = 2'b11
  } op_e;

  // dispatch stage state
  // a trap uop holds dispatch until it retires
  typedef enum logic {
    DISP_RUN       = 1'b0,
    DISP_WAIT_TRAP = 1'b1
  } disp_state_e;

endpackage

// File: rtl/vec_dispatch.sv
// vector uop dispatch stage
`timescale 1ns/1ps
`include "vec_rob_macros.svh"

module vec_dispatch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  vec_rob_pkg::op_e        in_op,
  input  logic [`VREG_IDX_W-1:0]  in_vd,
  input  logic [`DATA_W-1:0]      in_a,
  input  logic [`DATA_W-1:0]      in_b,
  output logic                    in_ready,
  input  logic                    rob_full,
  input  logic [`ROB_IDX_W-1:0]   alloc_entry,
  input  logic                    trap_valid,
  output logic                    alloc_valid,
  output logic [`VREG_IDX_W-1:0]  alloc_vd,
  output logic [`SEQ_W-1:0]       alloc_seq,
  output logic                    alloc_op_trap,
  output logic                    ex_valid,
  output vec_rob_pkg::op_e        ex_op,
  output logic [`ROB_IDX_W-1:0]   ex_entry,
  output logic [`DATA_W-1:0]      ex_a,
  output logic [`DATA_W-1:0]      ex_b
);

  vec_rob_pkg::disp_state_e state;
  logic                     st_valid;
  vec_rob_pkg::op_e         st_op;
  logic [`VREG_IDX_W-1:0]   st_vd;
  logic [`DATA_W-1:0]       st_a;
  logic [`DATA_W-1:0]       st_b;
  logic [`SEQ_W-1:0]        st_seq;
  logic [`SEQ_W-1:0]        seq_cnt;
  logic                     drain;
  logic                     accept;

  // stage empties whenever the rob has room
  assign drain = st_valid && !rob_full;

  // nothing is taken in behind a trap uop
  assign in_ready = (state == vec_rob_pkg::DISP_RUN) &&
                    (!st_valid || (drain && st_op != vec_rob_pkg::OP_TRAP));
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= vec_rob_pkg::DISP_RUN;
      st_valid <= 1'b0;
      seq_cnt  <= '0;
    end else begin
      if (accept) begin
        st_valid <= 1'b1;
        seq_cnt  <= seq_cnt + 1'b1;
      end else if (drain) begin
        st_valid <= 1'b0;
      end
      if (drain && st_op == vec_rob_pkg::OP_TRAP) begin
        state <= vec_rob_pkg::DISP_WAIT_TRAP;
      end else if (trap_valid) begin
        state <= vec_rob_pkg::DISP_RUN;
      end
    end
  end

  // uop payload, tagged with its sequence number on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      st_op  <= in_op;
      st_vd  <= in_vd;
      st_a   <= in_a;
      st_b   <= in_b;
      st_seq <= seq_cnt;
    end
  end

  // allocate and issue in the same cycle
  assign alloc_valid   = drain;
  assign alloc_vd      = st_vd;
  assign alloc_seq     = st_seq;
  assign alloc_op_trap = (st_op == vec_rob_pkg::OP_TRAP);
  assign ex_valid      = drain;
  assign ex_op         = st_op;
  assign ex_entry      = alloc_entry;
  assign ex_a          = st_a;
  assign ex_b          = st_b;

endmodule

// File: rtl/vec_exec.sv
// vector execution unit
`timescale 1ns/1ps
`include "vec_rob_macros.svh"

module vec_exec (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ex_valid,
  input  vec_rob_pkg::op_e       ex_op,
  input  logic [`ROB_IDX_W-1:0]  ex_entry,
  input  logic [`DATA_W-1:0]     ex_a,
  input  logic [`DATA_W-1:0]     ex_b,
  output logic                   wb0_valid,
  output logic [`ROB_IDX_W-1:0]  wb0_entry,
  output logic [`DATA_W-1:0]     wb0_data,
  output logic                   wb0_trap,
  output logic                   wb1_valid,
  output logic [`ROB_IDX_W-1:0]  wb1_entry,
  output logic [`DATA_W-1:0]     wb1_data
);

  logic [`MUL_LAT-1:0]  mul_vld;
  logic [`ROB_IDX_W-1:0] mul_ent  [`MUL_LAT];
  logic [`DATA_W-1:0]    mul_prod [`MUL_LAT];
  logic                  is_mul;

  assign is_mul = (ex_op == vec_rob_pkg::OP_MUL);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb0_valid <= 1'b0;
      mul_vld   <= '0;
    end else begin
      wb0_valid <= ex_valid && !is_mul;
      mul_vld   <= {mul_vld[`MUL_LAT-2:0], ex_valid && is_mul};
    end
  end

  // single-cycle path, trap writes back zero
  always_ff @(posedge clk) begin
    wb0_entry <= ex_entry;
    wb0_trap  <= (ex_op == vec_rob_pkg::OP_TRAP);
    case (ex_op)
      vec_rob_pkg::OP_ADD: wb0_data <= ex_a + ex_b;
      vec_rob_pkg::OP_SUB: wb0_data <= ex_a - ex_b;
      default:             wb0_data <= '0;
    endcase
  end

  // multiply pipeline, product formed in the first stage
  always_ff @(posedge clk) begin
    mul_ent[0]  <= ex_entry;
    mul_prod[0] <= ex_a * ex_b;
    for (int s = 1; s < `MUL_LAT; s++) begin
      mul_ent[s]  <= mul_ent[s-1];
      mul_prod[s] <= mul_prod[s-1];
    end
  end

  assign wb1_valid = mul_vld[`MUL_LAT-1];
  assign wb1_entry = mul_ent[`MUL_LAT-1];
  assign wb1_data  = mul_prod[`MUL_LAT-1];

endmodule

// File: rtl/vec_rob.sv
// vector reorder buffer
`timescale 1ns/1ps
`include "vec_rob_macros.svh"

module vec_rob (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                alloc_valid,
  input  logic [`VREG_IDX_W-1:0]              alloc_vd,
  input  logic [`SEQ_W-1:0]                   alloc_seq,
  input  logic                                alloc_op_trap,
  output logic [`ROB_IDX_W-1:0]               alloc_entry,
  output logic                                rob_full,
  input  logic                                wb0_valid,
  input  logic [`ROB_IDX_W-1:0]               wb0_entry,
  input  logic [`DATA_W-1:0]                  wb0_data,
  input  logic                                wb0_trap,
  input  logic                                wb1_valid,
  input  logic [`ROB_IDX_W-1:0]               wb1_entry,
  input  logic [`DATA_W-1:0]                  wb1_data,
  output logic [`NUM_RT-1:0]                  rt_valid,
  output logic [`NUM_RT-1:0][`VREG_IDX_W-1:0] rt_vd,
  output logic [`NUM_RT-1:0][`DATA_W-1:0]     rt_data,
  output logic [`NUM_RT-1:0]                  rt_trap,
  output logic [`NUM_RT-1:0][`SEQ_W-1:0]      rt_seq
);

  // control state per entry
  logic [`ROB_DEPTH-1:0]   ent_valid;
  logic [`ROB_DEPTH-1:0]   ent_done;
  logic [`ROB_DEPTH-1:0]   ent_trap;

  // payload per entry
  logic [`ROB_DEPTH-1:0]   ent_serial;
  logic [`VREG_IDX_W-1:0]  ent_vd   [`ROB_DEPTH];
  logic [`SEQ_W-1:0]       ent_seq  [`ROB_DEPTH];
  logic [`DATA_W-1:0]      ent_data [`ROB_DEPTH];

  logic [`ROB_IDX_W-1:0]   head;
  logic [`ROB_IDX_W-1:0]   tail;
  logic [`ROB_IDX_W:0]     count;
  logic [`ROB_IDX_W:0]     rt_num;
  logic [`ROB_IDX_W-1:0]   rt_idx [`NUM_RT];
  logic [`NUM_RT-1:0]      grp_end;

  assign alloc_entry = tail;
  assign rob_full    = (count == `ROB_DEPTH);

  // in-order retire window starting at head
  for (genvar k = 0; k < `NUM_RT; k++) begin : g_lane
    assign rt_idx[k]  = head + `ROB_IDX_W'(k);
    // a trap or a serializing uop closes the group
    assign grp_end[k] = ent_trap[rt_idx[k]] | ent_serial[rt_idx[k]];
    if (k == 0) begin : g_first
      assign rt_valid[k] = ent_valid[rt_idx[k]] && ent_done[rt_idx[k]];
    end else begin : g_next
      assign rt_valid[k] = rt_valid[k-1] && !grp_end[k-1] &&
                           ent_valid[rt_idx[k]] && ent_done[rt_idx[k]];
    end
    assign rt_vd[k]   = ent_vd[rt_idx[k]];
    assign rt_data[k] = ent_data[rt_idx[k]];
    assign rt_trap[k] = ent_trap[rt_idx[k]];
    assign rt_seq[k]  = ent_seq[rt_idx[k]];
  end

  always_comb begin
    rt_num = '0;
    for (int k = 0; k < `NUM_RT; k++) begin
      rt_num = rt_num + {{`ROB_IDX_W{1'b0}}, rt_valid[k]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      ent_valid <= '0;
      ent_done  <= '0;
      ent_trap  <= '0;
    end else begin
      head  <= head + rt_num[`ROB_IDX_W-1:0];
      count <= count + {{`ROB_IDX_W{1'b0}}, alloc_valid} - rt_num;
      for (int k = 0; k < `NUM_RT; k++) begin
        if (rt_valid[k]) begin
          ent_valid[rt_idx[k]] <= 1'b0;
        end
      end
      if (alloc_valid) begin
        tail            <= tail + 1'b1;
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        ent_trap[tail]  <= 1'b0;
      end
      // results may land in any order
      if (wb0_valid) begin
        ent_done[wb0_entry] <= 1'b1;
        ent_trap[wb0_entry] <= wb0_trap;
      end
      if (wb1_valid) begin
        ent_done[wb1_entry] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid) begin
      ent_vd[tail]     <= alloc_vd;
      ent_seq[tail]    <= alloc_seq;
      ent_serial[tail] <= alloc_op_trap;
    end
    if (wb0_valid) begin
      ent_data[wb0_entry] <= wb0_data;
    end
    if (wb1_valid) begin
      ent_data[wb1_entry] <= wb1_data;
    end
  end

endmodule

// File: rtl/vec_retire.sv
// vector retire and register file
`timescale 1ns/1ps
`include "vec_rob_macros.svh"

module vec_retire (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [`NUM_RT-1:0]                  rt_valid,
  input  logic [`NUM_RT-1:0][`VREG_IDX_W-1:0] rt_vd,
  input  logic [`NUM_RT-1:0][`DATA_W-1:0]     rt_data,
  input  logic [`NUM_RT-1:0]                  rt_trap,
  input  logic [`NUM_RT-1:0][`SEQ_W-1:0]      rt_seq,
  input  logic [`VREG_IDX_W-1:0]              rf_addr,
  output logic [`DATA_W-1:0]                  rf_data,
  output logic                                trap_valid,
  output logic [`SEQ_W-1:0]                   trap_seq
);

  logic [`DATA_W-1:0] vrf [`VREG_COUNT];

  // later lane overwrites earlier one on the same vd
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < `VREG_COUNT; r++) begin
        vrf[r] <= '0;
      end
      trap_valid <= 1'b0;
    end else begin
      trap_valid <= |(rt_valid & rt_trap);
      for (int k = 0; k < `NUM_RT; k++) begin
        if (rt_valid[k] && !rt_trap[k]) begin
          vrf[rt_vd[k]] <= rt_data[k];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < `NUM_RT; k++) begin
      if (rt_valid[k] && rt_trap[k]) begin
        trap_seq <= rt_seq[k];
      end
    end
  end

  assign rf_data = vrf[rf_addr];

endmodule

// File: rtl/vec_rob_top.sv
// vector rob backend top
`timescale 1ns/1ps
`include "vec_rob_macros.svh"

module vec_rob_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  vec_rob_pkg::op_e       in_op,
  input  logic [`VREG_IDX_W-1:0] in_vd,
  input  logic [`DATA_W-1:0]     in_a,
  input  logic [`DATA_W-1:0]     in_b,
  output logic                   in_ready,
  input  logic [`VREG_IDX_W-1:0] rf_addr,
  output logic [`DATA_W-1:0]     rf_data,
  output logic                   trap_valid,
  output logic [`SEQ_W-1:0]      trap_seq
);

  // dispatch to rob and exec
  logic                   alloc_valid;
  logic [`VREG_IDX_W-1:0] alloc_vd;
  logic [`SEQ_W-1:0]      alloc_seq;
  logic                   alloc_op_trap;
  logic [`ROB_IDX_W-1:0]  alloc_entry;
  logic                   rob_full;
  logic                   ex_valid;
  vec_rob_pkg::op_e       ex_op;
  logic [`ROB_IDX_W-1:0]  ex_entry;
  logic [`DATA_W-1:0]     ex_a;
  logic [`DATA_W-1:0]     ex_b;

  // writeback ports
  logic                   wb0_valid;
  logic [`ROB_IDX_W-1:0]  wb0_entry;
  logic [`DATA_W-1:0]     wb0_data;
  logic                   wb0_trap;
  logic                   wb1_valid;
  logic [`ROB_IDX_W-1:0]  wb1_entry;
  logic [`DATA_W-1:0]     wb1_data;

  // retire lanes
  logic [`NUM_RT-1:0]                  rt_valid;
  logic [`NUM_RT-1:0][`VREG_IDX_W-1:0] rt_vd;
  logic [`NUM_RT-1:0][`DATA_W-1:0]     rt_data;
  logic [`NUM_RT-1:0]                  rt_trap;
  logic [`NUM_RT-1:0][`SEQ_W-1:0]      rt_seq;

  vec_dispatch vec_dispatch_i (
    .clk(clk), .rst_n(rst_n),
    .in_valid(in_valid), .in_op(in_op), .in_vd(in_vd), .in_a(in_a), .in_b(in_b),
    .in_ready(in_ready), .rob_full(rob_full), .alloc_entry(alloc_entry),
    .trap_valid(trap_valid), .alloc_valid(alloc_valid), .alloc_vd(alloc_vd),
    .alloc_seq(alloc_seq), .alloc_op_trap(alloc_op_trap),
    .ex_valid(ex_valid), .ex_op(ex_op), .ex_entry(ex_entry), .ex_a(ex_a), .ex_b(ex_b)
  );

  vec_exec vec_exec_i (
    .clk(clk), .rst_n(rst_n),
    .ex_valid(ex_valid), .ex_op(ex_op), .ex_entry(ex_entry), .ex_a(ex_a), .ex_b(ex_b),
    .wb0_valid(wb0_valid), .wb0_entry(wb0_entry), .wb0_data(wb0_data),
    .wb0_trap(wb0_trap), .wb1_valid(wb1_valid), .wb1_entry(wb1_entry),
    .wb1_data(wb1_data)
  );

  vec_rob vec_rob_i (
    .clk(clk), .rst_n(rst_n),
    .alloc_valid(alloc_valid), .alloc_vd(alloc_vd), .alloc_seq(alloc_seq),
    .alloc_op_trap(alloc_op_trap), .alloc_entry(alloc_entry), .rob_full(rob_full),
    .wb0_valid(wb0_valid), .wb0_entry(wb0_entry), .wb0_data(wb0_data),
    .wb0_trap(wb0_trap), .wb1_valid(wb1_valid), .wb1_entry(wb1_entry),
    .wb1_data(wb1_data), .rt_valid(rt_valid), .rt_vd(rt_vd), .rt_data(rt_data),
    .rt_trap(rt_trap), .rt_seq(rt_seq)
  );

  vec_retire vec_retire_i (
    .clk(clk), .rst_n(rst_n),
    .rt_valid(rt_valid), .rt_vd(rt_vd), .rt_data(rt_data), .rt_trap(rt_trap),
    .rt_seq(rt_seq), .rf_addr(rf_addr), .rf_data(rf_data),
    .trap_valid(trap_valid), .trap_seq(trap_seq)
  );

endmodule

// File: sim/vec_rob_properties.sv
// rob occupancy and retire order checks
`timescale 1ns/1ps
`include "vec_rob_macros.svh"

module vec_rob_properties (
  input logic                clk,
  input logic                rst_n,
  input logic [`ROB_IDX_W:0] count,
  input logic                rob_full,
  input logic                alloc_valid,
  input logic [`NUM_RT-1:0]  rt_valid
);

  // occupancy stays within the entry store
  count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= `ROB_DEPTH)
    else $error("rob count %0d above depth", count);

  // lane 1 only retires behind lane 0
  lane_order: assert property (@(posedge clk) disable iff (!rst_n)
    rt_valid[1] |-> rt_valid[0])
    else $error("retire lane 1 valid without lane 0");

  no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
    rob_full |-> !alloc_valid)
    else $error("allocation while rob full");

endmodule

bind vec_rob vec_rob_properties vec_rob_properties_i (
  .clk(clk), .rst_n(rst_n), .count(count), .rob_full(rob_full),
  .alloc_valid(alloc_valid), .rt_valid(rt_valid)
);

// File: sim/vec_rob_tb.sv
// vector rob backend testbench
`timescale 1ns/1ps
`include "vec_rob_macros.svh"

module vec_rob_tb;

  localparam int NUM_ROWS = 22;
  localparam int WAIT_MAX = 100;

  logic                   clk;
  logic                   rst_n;
  logic                   in_valid;
  vec_rob_pkg::op_e       in_op;
  logic [`VREG_IDX_W-1:0] in_vd;
  logic [`DATA_W-1:0]     in_a;
  logic [`DATA_W-1:0]     in_b;
  logic                   in_ready;
  logic [`VREG_IDX_W-1:0] rf_addr;
  logic [`DATA_W-1:0]     rf_data;
  logic                   trap_valid;
  logic [`SEQ_W-1:0]      trap_seq;

  // stimulus rows in acceptance order
  vec_rob_pkg::op_e       row_op   [NUM_ROWS];
  logic [`VREG_IDX_W-1:0] row_vd   [NUM_ROWS];
  logic [`DATA_W-1:0]     row_a    [NUM_ROWS];
  logic [`DATA_W-1:0]     row_b    [NUM_ROWS];
  int                     row_hold [NUM_ROWS];

  logic [`DATA_W-1:0]     ref_rf [`VREG_COUNT];
  logic [`SEQ_W-1:0]      exp_traps [$];
  integer                 seed = 32'h5a454822;
  int                     errors;
  int                     timeouts;
  int                     traps_issued;
  int                     traps_seen;

  vec_rob_top vec_rob_top_i (
    .clk(clk), .rst_n(rst_n),
    .in_valid(in_valid), .in_op(in_op), .in_vd(in_vd), .in_a(in_a), .in_b(in_b),
    .in_ready(in_ready), .rf_addr(rf_addr), .rf_data(rf_data),
    .trap_valid(trap_valid), .trap_seq(trap_seq)
  );

  always #5 clk = ~clk;

  task automatic set_row(input int i, input vec_rob_pkg::op_e op, input int vd,
                         input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b,
                         input int hold);
    row_op[i]   = op;
    row_vd[i]   = `VREG_IDX_W'(vd);
    row_a[i]    = a;
    row_b[i]    = b;
    row_hold[i] = hold;
  endtask

  task automatic fill_table();
    set_row(0, vec_rob_pkg::OP_ADD, 1, 32'd10, 32'd5, 0);
    set_row(1, vec_rob_pkg::OP_MUL, 4, $random(seed), $random(seed), 0);
    // younger add to the same register finishes before the multiply
    set_row(2, vec_rob_pkg::OP_ADD, 4, 32'd3, 32'd4, 0);
    set_row(3, vec_rob_pkg::OP_SUB, 2, 32'd100, 32'd1, 1);
    set_row(4, vec_rob_pkg::OP_MUL, 5, $random(seed), $random(seed), 0);
    set_row(5, vec_rob_pkg::OP_SUB, 3, $random(seed), $random(seed), 2);
    set_row(6, vec_rob_pkg::OP_TRAP, 6, 32'h0000dead, 32'h0000beef, 0);
    set_row(7, vec_rob_pkg::OP_ADD, 6, 32'd1, 32'd2, 0);
    // burst of multiplies, more than the rob holds
    for (int i = 8; i < 18; i++) begin
      set_row(i, vec_rob_pkg::OP_MUL, i % 8, $random(seed), $random(seed), 0);
    end
    // v2 keeps its burst product, nothing later writes it
    set_row(18, vec_rob_pkg::OP_TRAP, 2, 32'd0, 32'd0, 1);
    set_row(19, vec_rob_pkg::OP_ADD, 7, $random(seed), $random(seed), 0);
    set_row(20, vec_rob_pkg::OP_MUL, 1, $random(seed), $random(seed), 0);
    // sub finishes first, then retires beside the multiply to v1
    set_row(21, vec_rob_pkg::OP_SUB, 1, 32'd5, 32'd9, 0);
  endtask

  // program-order register state and trap sequence numbers
  task automatic build_reference();
    for (int r = 0; r < `VREG_COUNT; r++) begin
      ref_rf[r] = '0;
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      case (row_op[i])
        vec_rob_pkg::OP_ADD: ref_rf[row_vd[i]] = row_a[i] + row_b[i];
        vec_rob_pkg::OP_SUB: ref_rf[row_vd[i]] = row_a[i] - row_b[i];
        vec_rob_pkg::OP_MUL: ref_rf[row_vd[i]] = row_a[i] * row_b[i];
        default:             exp_traps.push_back(`SEQ_W'(i));
      endcase
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(input logic [`VREG_IDX_W-1:0] idx, input logic [`DATA_W-1:0] exp);
    @(posedge clk);
    #1;
    rf_addr = idx;
    @(negedge clk);
    if (rf_data !== exp) begin
      errors++;
      $display("Fail at %0t ns: v%0d reads %h, expected %h", $time, idx, rf_data, exp);
    end
  endtask

  task automatic check_trap(input logic [`SEQ_W-1:0] exp);
    if (trap_seq !== exp) begin
      errors++;
      $display("Fail at %0t ns: trap_seq is %0d, expected %0d", $time, trap_seq, exp);
    end
  endtask

  // trap pulses sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && trap_valid) begin
      traps_seen++;
      if (exp_traps.size() == 0) begin
        errors++;
        $display("unexpected trap pulse at %0t ns", $time);
      end else begin
        check_trap(exp_traps.pop_front());
      end
    end
  end

  // entered and left 1 ns after a rising edge
  task automatic apply_row(input int i);
    int waited;
    waited     = 0;
    in_valid   = 1'b1;
    in_op      = row_op[i];
    in_vd      = row_vd[i];
    in_a       = row_a[i];
    in_b       = row_b[i];
    @(negedge clk);
    while (!in_ready && waited < WAIT_MAX) begin
      waited++;
      @(negedge clk);
    end
    if (!in_ready) begin
      timeouts++;
      $display("timed out waiting for in_ready on row %0d", i);
    end else if (traps_seen < traps_issued) begin
      errors++;
      $display("Fail at %0t ns: in_ready high before trap pulse, row %0d", $time, i);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    if (row_op[i] == vec_rob_pkg::OP_TRAP) begin
      traps_issued++;
    end
    for (int h = 0; h < row_hold[i]; h++) begin
      @(posedge clk);
      #1;
    end
  endtask

  // rob empty for a few cycles in a row
  task automatic wait_drain();
    int idle;
    int waited;
    idle   = 0;
    waited = 0;
    while (idle < 3 && waited < WAIT_MAX) begin
      @(negedge clk);
      waited++;
      if (vec_rob_top_i.vec_rob_i.count == 0) begin
        idle++;
      end else begin
        idle = 0;
      end
    end
    if (idle < 3) begin
      timeouts++;
      $display("timed out waiting for the ROB to drain");
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_op        = vec_rob_pkg::OP_ADD;
    in_vd        = '0;
    in_a         = '0;
    in_b         = '0;
    rf_addr      = '0;
    errors       = 0;
    timeouts     = 0;
    traps_issued = 0;
    traps_seen   = 0;
    fill_table();
    build_reference();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("in_ready", in_ready, 1'b1);
    check_flag("trap_valid", trap_valid, 1'b0);
    for (int r = 0; r < `VREG_COUNT; r++) begin
      check_reg(`VREG_IDX_W'(r), '0);
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(i);
    end
    wait_drain();
    for (int r = 0; r < `VREG_COUNT; r++) begin
      check_reg(`VREG_IDX_W'(r), ref_rf[r]);
    end
    if (exp_traps.size() != 0) begin
      errors++;
      $display("%0d expected trap pulses never arrived", exp_traps.size());
    end
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+include
rtl/vec_rob_pkg.sv
rtl/vec_dispatch.sv
rtl/vec_exec.sv
rtl/vec_rob.sv
rtl/vec_retire.sv
rtl/vec_rob_top.sv
sim/vec_rob_properties.sv
sim/vec_rob_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the vec_rob testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=vec_rob_sim

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module vec_rob_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0
